// File: compile.f
logic/rename_pkg.sv
logic/rename_ctrl.sv
logic/spec_rat.sv
logic/retire_rat.sv
logic/free_list.sv
logic/rename_stage.sv
logic/rename_unit.sv
dv/rename_unit_sva.sv
dv/tb_rename_unit.sv

// File: dv/rename_patterns.txt
# name op | slot 0: valid has_rd rd has_rs1 rs1 has_rs2 rs2 | slot 1: the same seven
# | expected prd prs1 prs2 of slot 0, then slot 1 (idle: first is in_ready, retire: rd prd)
b1_identity rename 1 1 01 1 02 1 03  1 1 04 1 05 1 06  20 02 03 21 05 06
b2_bypass rename 1 1 07 1 01 1 04  1 1 08 1 07 1 01  22 20 21 23 22 20
b2_same_rd rename 1 1 09 1 08 0 00  1 1 09 1 09 1 07  24 23 00 25 24 22
b6_no_rd rename 1 0 0a 1 09 1 08  1 1 00 1 07 1 01  00 25 23 00 22 20
b6_invalid rename 0 1 0b 1 01 1 02  1 1 0c 1 0b 1 0a  00 00 00 26 0b 0a
b4_stall stall 1 1 0d 1 0c 1 01  1 1 0e 1 0d 1 0c  27 26 20 28 27 26
b4_resume rename 1 1 0f 1 0e 1 0d  1 1 10 1 0f 0 0c  29 28 27 2a 29 00
b3_fill0 rename 1 1 11 1 10 0 00  1 1 12 1 11 0 00  2b 2a 00 2c 2b 00
b3_fill1 rename 1 1 13 1 12 0 00  1 1 14 1 13 0 00  2d 2c 00 2e 2d 00
b3_fill2 rename 1 1 15 1 14 0 00  1 1 16 1 15 0 00  2f 2e 00 30 2f 00
b3_fill3 rename 1 1 17 1 16 0 00  1 1 18 1 17 0 00  31 30 00 32 31 00
b3_fill4 rename 1 1 19 1 18 0 00  1 1 1a 1 19 0 00  33 32 00 34 33 00
b3_fill5 rename 1 1 1b 1 1a 0 00  1 1 1c 1 1b 0 00  35 34 00 36 35 00
b3_fill6 rename 1 1 1d 1 1c 0 00  1 1 1e 1 1d 0 00  37 36 00 38 37 00
b3_fill7 rename 1 1 1f 1 1e 0 00  1 1 01 1 1f 0 00  39 38 00 3a 39 00
b3_fill8 rename 1 1 02 1 01 0 00  1 1 03 1 02 0 00  3b 3a 00 3c 3b 00
b3_fill9 rename 1 1 04 1 03 0 00  1 1 05 1 04 0 00  3d 3c 00 3e 3d 00
b3_held idle 1 1 06 1 05 0 00  1 1 07 1 06 0 00  00 00 00 00 00 00
b3_retire retire 01 20 00 00 00 00 00  00 00 00 00 00 00 00  00 00 00 00 00 00
b3_granted rename 1 1 06 1 05 0 00  1 1 07 1 06 0 00  01 3e 00 3f 01 00
b3_empty idle 1 1 08 1 06 0 00  0 0 00 0 00 0 00  00 00 00 00 00 00
b6_no_dest rename 1 1 00 1 06 1 07  1 0 03 1 01 1 02  00 01 3f 00 3a 3b
b5_retire retire 04 21 00 00 00 00 00  00 00 00 00 00 00 00  00 00 00 00 00 00
b5_flush flush 00 00 00 00 00 00 00  00 00 00 00 00 00 00  00 00 00 00 00 00
b5_restored rename 1 1 07 1 01 1 07  1 1 02 1 04 1 08  01 20 07 04 21 08
b5_latest rename 1 1 08 1 07 1 02  0 1 09 1 03 1 03  22 01 04 00 00 00

// File: dv/rename_unit_sva.sv
`default_nettype none

module rename_unit_sva (
    input logic                                clk,
    input logic                                arst_n,
    input logic                                flush,
    input logic                                in_ready,
    input logic                                out_valid,
    input logic                                out_ready,
    input rename_pkg::ren_uop_t                out_uops [rename_pkg::RENAME_WIDTH],
    input rename_pkg::retire_t                 retire,
    input logic                                recover,
    input logic [rename_pkg::RENAME_WIDTH-1:0] wr_en,
    input rename_pkg::phys_reg_t               wr_phys [rename_pkg::RENAME_WIDTH]
);

    timeunit 1ns;
    timeprecision 1ps;

    // Number of failed assertions
    int unsigned fail_count = 0;

    logic [$bits(rename_pkg::ren_uop_t)*rename_pkg::RENAME_WIDTH-1:0] out_flat;

    assign out_flat = {out_uops[1], out_uops[0]};

    flush_blocks_input: assert property (
        @(posedge clk) disable iff (!arst_n) flush |-> !in_ready
    ) else begin
        $error("in_ready high in a flush cycle");
        fail_count++;
    end

    // Payload frozen while dispatch stalls
    output_held: assert property (
        @(posedge clk) disable iff (!arst_n) (out_valid && !out_ready) |=> $stable(out_flat)
    ) else begin
        $error("out_uops changed under back-pressure");
        fail_count++;
    end

    no_retire_in_recover: assert property (
        @(posedge clk) disable iff (!arst_n) recover |-> !retire.valid
    ) else begin
        $error("retirement during recovery");
        fail_count++;
    end

    // Registers handed to the two slots of one bundle
    distinct_alloc: assert property (
        @(posedge clk) disable iff (!arst_n) (&wr_en) |-> (wr_phys[0] != wr_phys[1])
    ) else begin
        $error("same physical register allocated twice");
        fail_count++;
    end

endmodule

bind rename_unit rename_unit_sva u_sva (
    .clk       (clk),
    .arst_n    (arst_n),
    .flush     (flush),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_uops  (out_uops),
    .retire    (retire),
    .recover   (recover),
    .wr_en     (wr_en),
    .wr_phys   (wr_phys)
);

`default_nettype wire

// File: dv/tb_rename_unit.sv
`default_nettype none

module tb_rename_unit;

    timeunit 1ns;
    timeprecision 1ps;

    localparam string PATTERN_FILE    = "dv/rename_patterns.txt";
    localparam int    SEED_INIT       = 91;
    localparam int    CYCLES_PER_STEP = 40;
    localparam int    NUM_FIELDS      = 20;
    localparam int    MAX_STEPS       = 64;
    // Expected values start after the two slots of seven fields
    localparam int    EXP_BASE        = 14;

    logic                 clk;
    logic                 arst_n;
    logic                 flush;
    logic                 in_valid;
    logic                 in_ready;
    rename_pkg::dec_uop_t in_uops [rename_pkg::RENAME_WIDTH];
    logic                 out_valid;
    logic                 out_ready;
    rename_pkg::ren_uop_t out_uops [rename_pkg::RENAME_WIDTH];
    rename_pkg::retire_t  retire;

    string      step_name [MAX_STEPS];
    string      step_op [MAX_STEPS];
    logic [7:0] step_val [MAX_STEPS][NUM_FIELDS];
    int         num_steps   = 0;

    int seed;
    int cycles      = 0;
    int cycle_limit = CYCLES_PER_STEP;
    int errors      = 0;
    int step_errors = 0;
    int good_steps  = 0;
    int bad_steps   = 0;

    rename_unit DUT (
        .clk       (clk),
        .arst_n    (arst_n),
        .flush     (flush),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_uops   (in_uops),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_uops  (out_uops),
        .retire    (retire)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout: no progress within %0d cycles", cycle_limit);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    //******************************
    // Pattern loading
    //******************************

    task automatic load_patterns();
        int         fd;
        int         got;
        int         n;
        string      line;
        string      name;
        string      op;
        logic [7:0] v [NUM_FIELDS];
        fd = $fopen(PATTERN_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open pattern file %s", PATTERN_FILE);
            errors++;
        end else begin
            while (!$feof(fd) && num_steps < MAX_STEPS) begin
                line = "";
                got = $fgets(line, fd);
                if (got != 0 && line.len() > 1 && line[0] != "#") begin
                    n = $sscanf(line,
                        "%s %s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        name, op, v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8],
                        v[9], v[10], v[11], v[12], v[13], v[14], v[15], v[16], v[17],
                        v[18], v[19]);
                    if (n != NUM_FIELDS + 2) begin
                        $display("Malformed pattern line: %s", line);
                        errors++;
                    end else begin
                        step_name[num_steps] = name;
                        step_op[num_steps]   = op;
                        for (int k = 0; k < NUM_FIELDS; k++) begin
                            step_val[num_steps][k] = v[k];
                        end
                        num_steps++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    //******************************
    // Drive and check helpers
    //******************************

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic set_bundle(input int idx);
        int b;
        for (int w = 0; w < rename_pkg::RENAME_WIDTH; w++) begin
            b = 7 * w;
            in_uops[w].valid   = step_val[idx][b][0];
            in_uops[w].has_rd  = step_val[idx][b+1][0];
            in_uops[w].rd      = step_val[idx][b+2][4:0];
            in_uops[w].has_rs1 = step_val[idx][b+3][0];
            in_uops[w].rs1     = step_val[idx][b+4][4:0];
            in_uops[w].has_rs2 = step_val[idx][b+5][0];
            in_uops[w].rs2     = step_val[idx][b+6][4:0];
            in_uops[w].tag     = rename_pkg::uop_tag_t'(idx * rename_pkg::RENAME_WIDTH + w);
        end
    endtask

    task automatic check_reg(input string name, input string field, input int slot,
                             input rename_pkg::phys_reg_t exp,
                             input rename_pkg::phys_reg_t act);
        if (exp !== act) begin
            $display("Mismatch %s slot %0d %s: expected %h, actual %h",
                     name, slot, field, exp, act);
            step_errors++;
        end
    endtask

    task automatic compare_outputs(input int idx);
        int e;
        for (int w = 0; w < rename_pkg::RENAME_WIDTH; w++) begin
            e = EXP_BASE + 3 * w;
            check_reg(step_name[idx], "prd", w, step_val[idx][e][5:0], out_uops[w].prd);
            check_reg(step_name[idx], "prs1", w, step_val[idx][e+1][5:0], out_uops[w].prs1);
            check_reg(step_name[idx], "prs2", w, step_val[idx][e+2][5:0], out_uops[w].prs2);
            // Decoded fields ride through untouched
            if (out_uops[w].uop !== in_uops[w]) begin
                $display("Mismatch %s slot %0d uop: expected %h, actual %h",
                         step_name[idx], w, in_uops[w], out_uops[w].uop);
                step_errors++;
            end
        end
    endtask

    // Transfer happens on the edge after in_ready is seen high
    task automatic wait_accept();
        @(negedge clk);
        while (!in_ready) begin
            @(negedge clk);
        end
        next_cycle();
        in_valid = 1'b0;
    endtask

    task automatic wait_out_valid();
        @(negedge clk);
        while (!out_valid) begin
            @(negedge clk);
        end
    endtask

    //******************************
    // Step operations
    //******************************

    task automatic rename_bundle(input int idx, input logic stall);
        int                   hold;
        rename_pkg::ren_uop_t held [rename_pkg::RENAME_WIDTH];
        set_bundle(idx);
        in_valid  = 1'b1;
        out_ready = !stall;
        wait_accept();
        wait_out_valid();
        if (stall) begin
            hold = 2 + int'($unsigned($random(seed)) % 6);
            held = out_uops;
            for (int c = 0; c < hold; c++) begin
                @(negedge clk);
                if (in_ready) begin
                    $display("%s: in_ready high while out_ready was low", step_name[idx]);
                    step_errors++;
                end
                if (!out_valid) begin
                    $display("%s: out_valid dropped while out_ready was low", step_name[idx]);
                    step_errors++;
                end
                for (int w = 0; w < rename_pkg::RENAME_WIDTH; w++) begin
                    if (out_uops[w] !== held[w]) begin
                        $display("%s: output slot %0d changed under back-pressure",
                                 step_name[idx], w);
                        step_errors++;
                    end
                end
            end
        end
        compare_outputs(idx);
        next_cycle();
        out_ready = 1'b1;
    endtask

    task automatic retire_write(input int idx);
        retire.valid = 1'b1;
        retire.rd    = step_val[idx][0][4:0];
        retire.prd   = step_val[idx][1][5:0];
        next_cycle();
        retire = '0;
    endtask

    task automatic pulse_flush(input int idx);
        // Empty bundle, which needs no register and is ready whenever renaming runs
        set_bundle(idx);
        in_valid  = 1'b0;
        out_ready = 1'b1;
        flush     = 1'b1;
        @(negedge clk);
        if (in_ready) begin
            $display("%s: in_ready high in the flush cycle", step_name[idx]);
            step_errors++;
        end
        next_cycle();
        flush = 1'b0;
        @(negedge clk);
        if (in_ready) begin
            $display("%s: in_ready high in the recovery cycle", step_name[idx]);
            step_errors++;
        end
        next_cycle();
        // Second pulse hits a bundle parked in the output register
        in_valid  = 1'b1;
        out_ready = 1'b0;
        wait_accept();
        flush = 1'b1;
        next_cycle();
        flush     = 1'b0;
        out_ready = 1'b1;
        @(negedge clk);
        if (out_valid) begin
            $display("%s: out_valid still high after flush", step_name[idx]);
            step_errors++;
        end
        next_cycle();
    endtask

    // Bundle shown with in_valid low while in_ready is compared each cycle
    task automatic hold_idle(input int idx);
        logic exp_ready;
        set_bundle(idx);
        in_valid  = 1'b0;
        exp_ready = step_val[idx][EXP_BASE][0];
        for (int c = 0; c < 3; c++) begin
            @(negedge clk);
            if (in_ready !== exp_ready) begin
                $display("Mismatch %s in_ready: expected %b, actual %b",
                         step_name[idx], exp_ready, in_ready);
                step_errors++;
            end
            next_cycle();
        end
    endtask

    task automatic execute_step(input int idx);
        step_errors = 0;
        if (step_op[idx] == "rename") begin
            rename_bundle(idx, 1'b0);
        end else if (step_op[idx] == "stall") begin
            rename_bundle(idx, 1'b1);
        end else if (step_op[idx] == "retire") begin
            retire_write(idx);
        end else if (step_op[idx] == "flush") begin
            pulse_flush(idx);
        end else if (step_op[idx] == "idle") begin
            hold_idle(idx);
        end else begin
            $display("%s: unknown operation %s", step_name[idx], step_op[idx]);
            step_errors++;
        end
        errors += step_errors;
        if (step_errors == 0) begin
            good_steps++;
            $display("%s: ok", step_name[idx]);
        end else begin
            bad_steps++;
            $display("%s: %0d errors", step_name[idx], step_errors);
        end
    endtask

    //******************************
    // Main sequence
    //******************************

    initial begin
        seed      = SEED_INIT;
        arst_n    = 1'b0;
        flush     = 1'b0;
        in_valid  = 1'b0;
        out_ready = 1'b1;
        retire    = '0;
        for (int w = 0; w < rename_pkg::RENAME_WIDTH; w++) begin
            in_uops[w] = '0;
        end
        load_patterns();
        cycle_limit = CYCLES_PER_STEP * (num_steps + 1);

        repeat (3) @(posedge clk);
        #1;
        arst_n = 1'b1;
        // Still recovering from reset in this cycle
        @(negedge clk);
        if (in_ready || out_valid) begin
            $display("reset: in_ready or out_valid high before the first edge after reset");
            errors++;
        end else begin
            $display("reset: ok");
        end
        next_cycle();

        for (int i = 0; i < num_steps; i++) begin
            execute_step(i);
        end

        errors += int'(DUT.u_sva.fail_count);
        $display("Steps: %0d run, %0d ok, %0d with errors, %0d errors in total",
                 num_steps, good_steps, bad_steps, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: logic/free_list.sv
`default_nettype none

module free_list (
    input  logic                                 clk,
    input  logic                                 arst_n,
    input  logic [rename_pkg::RENAME_WIDTH-1:0]  alloc,
    input  logic                                 free_valid,
    input  rename_pkg::phys_reg_t                free_phys,
    input  logic                                 recover,
    input  logic [rename_pkg::NUM_PHYS_REGS-1:0] mapped_bits,
    output rename_pkg::phys_reg_t                pick [rename_pkg::RENAME_WIDTH],
    output rename_pkg::reg_count_t               free_count
);

    // Bit i set means p<i> can be handed out
    logic [rename_pkg::NUM_PHYS_REGS-1:0] free_bits;
    logic [rename_pkg::NUM_PHYS_REGS-1:0] next_bits;

    //******************************
    // Lowest-first pick and count
    //******************************

    always_comb begin
        int n;
        n = 0;
        for (int k = 0; k < rename_pkg::RENAME_WIDTH; k++) begin
            pick[k] = '0;
        end
        for (int i = 0; i < rename_pkg::NUM_PHYS_REGS; i++) begin
            if (free_bits[i]) begin
                if (n < rename_pkg::RENAME_WIDTH) begin
                    pick[n] = rename_pkg::phys_reg_t'(i);
                end
                n++;
            end
        end
        free_count = rename_pkg::reg_count_t'(n);
    end

    //******************************
    // Bitmap update
    //******************************

    always_comb begin
        next_bits = free_bits;
        for (int k = 0; k < rename_pkg::RENAME_WIDTH; k++) begin
            if (alloc[k]) begin
                next_bits[pick[k]] = 1'b0;
            end
        end
        // Freed reg is held by the retire table, never one of the picks
        if (free_valid) begin
            next_bits[free_phys] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            // Registers above the architectural ones start free
            for (int i = 0; i < rename_pkg::NUM_PHYS_REGS; i++) begin
                free_bits[i] <= (i >= rename_pkg::NUM_ARCH_REGS);
            end
        end else if (recover) begin
            // Rebuilt from whatever the retire table does not hold
            free_bits <= ~mapped_bits;
        end else begin
            free_bits <= next_bits;
        end
    end

endmodule

`default_nettype wire

// File: logic/rename_ctrl.sv
`default_nettype none

module rename_ctrl (
    input  logic clk,
    input  logic arst_n,
    input  logic flush,
    output logic rename_en,
    output logic recover
);

    rename_pkg::ctrl_state_t state;
    rename_pkg::ctrl_state_t state_next;

    // A flush costs exactly one recovery cycle
    always_comb begin
        state_next = state;
        case (state)
            rename_pkg::RUN: begin
                if (flush) begin
                    state_next = rename_pkg::RECOVER;
                end
            end
            rename_pkg::RECOVER: begin
                state_next = rename_pkg::RUN;
            end
            default: begin
                state_next = rename_pkg::RUN;
            end
        endcase
    end

    // Comes out of reset through one recovery cycle, so the decoder
    // sees in_ready low until the first edge after release
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= rename_pkg::RECOVER;
        end else begin
            state <= state_next;
        end
    end

    assign recover   = (state == rename_pkg::RECOVER);
    assign rename_en = (state == rename_pkg::RUN) && !flush;

endmodule

`default_nettype wire

// File: logic/rename_pkg.sv
`default_nettype none

package rename_pkg;

    //******************************
    // Sizes
    //******************************

    // Micro-ops renamed per cycle
    localparam int RENAME_WIDTH = 2;

    localparam int NUM_ARCH_REGS = 32;
    localparam int NUM_PHYS_REGS = 64;

    // rs1 and rs2 of every slot
    localparam int SRCS_PER_UOP = 2;
    localparam int NUM_SRCS     = RENAME_WIDTH * SRCS_PER_UOP;

    //******************************
    // Register types
    //******************************

    typedef logic [$clog2(NUM_ARCH_REGS)-1:0] arch_reg_t;
    typedef logic [$clog2(NUM_PHYS_REGS)-1:0] phys_reg_t;

    // Counts 0 up to all physical registers
    typedef logic [$clog2(NUM_PHYS_REGS+1)-1:0] reg_count_t;

    // Rest of the micro-op, opaque to rename
    typedef logic [7:0] uop_tag_t;

    //******************************
    // Micro-op structs
    //******************************

    typedef struct packed {
        logic      valid;
        logic      has_rd;
        arch_reg_t rd;
        logic      has_rs1;
        arch_reg_t rs1;
        logic      has_rs2;
        arch_reg_t rs2;
        uop_tag_t  tag;
    } dec_uop_t;

    typedef struct packed {
        dec_uop_t  uop;
        phys_reg_t prd;
        phys_reg_t prs1;
        phys_reg_t prs2;
    } ren_uop_t;

    // One retiring register write
    typedef struct packed {
        logic      valid;
        arch_reg_t rd;
        phys_reg_t prd;
    } retire_t;

    typedef enum logic {
        RUN,
        RECOVER
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: logic/rename_stage.sv
`default_nettype none

module rename_stage (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                rename_en,
    input  logic                                flush,
    input  logic                                in_valid,
    input  rename_pkg::dec_uop_t                in_uops [rename_pkg::RENAME_WIDTH],
    input  logic                                out_ready,
    input  rename_pkg::phys_reg_t               pick [rename_pkg::RENAME_WIDTH],
    input  rename_pkg::reg_count_t              free_count,
    input  rename_pkg::phys_reg_t               src_phys [rename_pkg::NUM_SRCS],
    output logic                                in_ready,
    output logic                                out_valid,
    output rename_pkg::ren_uop_t                out_uops [rename_pkg::RENAME_WIDTH],
    output rename_pkg::arch_reg_t               src_arch [rename_pkg::NUM_SRCS],
    output logic [rename_pkg::RENAME_WIDTH-1:0] wr_en,
    output rename_pkg::arch_reg_t               wr_arch [rename_pkg::RENAME_WIDTH],
    output rename_pkg::phys_reg_t               wr_phys [rename_pkg::RENAME_WIDTH],
    output logic [rename_pkg::RENAME_WIDTH-1:0] alloc
);

    logic [rename_pkg::RENAME_WIDTH-1:0] need;
    logic [rename_pkg::RENAME_WIDTH-1:0] use_pick;
    rename_pkg::phys_reg_t               prd [rename_pkg::RENAME_WIDTH];
    rename_pkg::reg_count_t              need_count;
    rename_pkg::ren_uop_t                next_uops [rename_pkg::RENAME_WIDTH];
    logic                                out_free;
    logic                                transfer;

    //******************************
    // Destination allocation
    //******************************

    // Needing slots take the picks in slot order
    always_comb begin
        int idx;
        idx = 0;
        use_pick = '0;
        for (int w = 0; w < rename_pkg::RENAME_WIDTH; w++) begin
            need[w] = in_uops[w].valid && in_uops[w].has_rd && (in_uops[w].rd != '0);
            prd[w]  = '0;
            if (need[w]) begin
                prd[w]        = pick[idx];
                use_pick[idx] = 1'b1;
                idx++;
            end
        end
        need_count = rename_pkg::reg_count_t'(idx);
    end

    // Output register can take a bundle if empty or draining this cycle
    assign out_free = !out_valid || out_ready;

    // All or nothing: a short free list holds the whole bundle
    assign in_ready = rename_en && out_free && (free_count >= need_count);
    assign transfer = in_valid && in_ready;

    assign alloc = transfer ? use_pick : '0;

    //******************************
    // Map table ports and assembly
    //******************************

    always_comb begin
        for (int w = 0; w < rename_pkg::RENAME_WIDTH; w++) begin
            src_arch[rename_pkg::SRCS_PER_UOP*w]     = in_uops[w].rs1;
            src_arch[rename_pkg::SRCS_PER_UOP*w + 1] = in_uops[w].rs2;

            wr_en[w]   = transfer && need[w];
            wr_arch[w] = in_uops[w].rd;
            wr_phys[w] = prd[w];

            next_uops[w].uop  = in_uops[w];
            next_uops[w].prd  = prd[w];
            next_uops[w].prs1 = '0;
            next_uops[w].prs2 = '0;
            if (in_uops[w].valid && in_uops[w].has_rs1) begin
                next_uops[w].prs1 = src_phys[rename_pkg::SRCS_PER_UOP*w];
            end
            if (in_uops[w].valid && in_uops[w].has_rs2) begin
                next_uops[w].prs2 = src_phys[rename_pkg::SRCS_PER_UOP*w + 1];
            end
        end
    end

    //******************************
    // Output register
    //******************************

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else if (flush) begin
            out_valid <= 1'b0;
        end else if (transfer) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    // Payload only moves on a transfer, so it holds under back-pressure
    always_ff @(posedge clk) begin
        if (transfer) begin
            for (int w = 0; w < rename_pkg::RENAME_WIDTH; w++) begin
                out_uops[w] <= next_uops[w];
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/rename_unit.sv
`default_nettype none

module rename_unit (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  flush,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  rename_pkg::dec_uop_t  in_uops [rename_pkg::RENAME_WIDTH],
    output logic                  out_valid,
    input  logic                  out_ready,
    output rename_pkg::ren_uop_t  out_uops [rename_pkg::RENAME_WIDTH],
    input  rename_pkg::retire_t   retire
);

    // Controller
    logic rename_en;
    logic recover;

    // Speculative map ports
    rename_pkg::arch_reg_t               src_arch [rename_pkg::NUM_SRCS];
    rename_pkg::phys_reg_t               src_phys [rename_pkg::NUM_SRCS];
    logic [rename_pkg::RENAME_WIDTH-1:0] wr_en;
    rename_pkg::arch_reg_t               wr_arch [rename_pkg::RENAME_WIDTH];
    rename_pkg::phys_reg_t               wr_phys [rename_pkg::RENAME_WIDTH];

    // Retire map outputs
    rename_pkg::phys_reg_t                retire_map [rename_pkg::NUM_ARCH_REGS];
    logic [rename_pkg::NUM_PHYS_REGS-1:0] mapped_bits;
    logic                                 free_valid;
    rename_pkg::phys_reg_t                free_phys;

    // Free list
    rename_pkg::phys_reg_t               pick [rename_pkg::RENAME_WIDTH];
    rename_pkg::reg_count_t              free_count;
    logic [rename_pkg::RENAME_WIDTH-1:0] alloc;

    rename_ctrl u_ctrl (
        .clk       (clk),
        .arst_n    (arst_n),
        .flush     (flush),
        .rename_en (rename_en),
        .recover   (recover)
    );

    spec_rat u_spec_rat (
        .clk        (clk),
        .arst_n     (arst_n),
        .src_arch   (src_arch),
        .wr_en      (wr_en),
        .wr_arch    (wr_arch),
        .wr_phys    (wr_phys),
        .recover    (recover),
        .retire_map (retire_map),
        .src_phys   (src_phys)
    );

    retire_rat u_retire_rat (
        .clk         (clk),
        .arst_n      (arst_n),
        .retire      (retire),
        .retire_map  (retire_map),
        .mapped_bits (mapped_bits),
        .free_valid  (free_valid),
        .free_phys   (free_phys)
    );

    free_list u_free_list (
        .clk         (clk),
        .arst_n      (arst_n),
        .alloc       (alloc),
        .free_valid  (free_valid),
        .free_phys   (free_phys),
        .recover     (recover),
        .mapped_bits (mapped_bits),
        .pick        (pick),
        .free_count  (free_count)
    );

    rename_stage u_stage (
        .clk        (clk),
        .arst_n     (arst_n),
        .rename_en  (rename_en),
        .flush      (flush),
        .in_valid   (in_valid),
        .in_uops    (in_uops),
        .out_ready  (out_ready),
        .pick       (pick),
        .free_count (free_count),
        .src_phys   (src_phys),
        .in_ready   (in_ready),
        .out_valid  (out_valid),
        .out_uops   (out_uops),
        .src_arch   (src_arch),
        .wr_en      (wr_en),
        .wr_arch    (wr_arch),
        .wr_phys    (wr_phys),
        .alloc      (alloc)
    );

endmodule

`default_nettype wire

// File: logic/retire_rat.sv
`default_nettype none

module retire_rat (
    input  logic                                 clk,
    input  logic                                 arst_n,
    input  rename_pkg::retire_t                  retire,
    output rename_pkg::phys_reg_t                retire_map [rename_pkg::NUM_ARCH_REGS],
    output logic [rename_pkg::NUM_PHYS_REGS-1:0] mapped_bits,
    output logic                                 free_valid,
    output rename_pkg::phys_reg_t                free_phys
);

    rename_pkg::phys_reg_t map [rename_pkg::NUM_ARCH_REGS];
    logic                  retire_wr;

    // x0 stays pinned to p0
    assign retire_wr = retire.valid && (retire.rd != '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int a = 0; a < rename_pkg::NUM_ARCH_REGS; a++) begin
                map[a] <= rename_pkg::phys_reg_t'(a);
            end
        end else if (retire_wr) begin
            map[retire.rd] <= retire.prd;
        end
    end

    // Old mapping is released as the new one commits
    assign free_valid = retire_wr;
    assign free_phys  = map[retire.rd];

    assign retire_map = map;

    // Every physical register held by the committed state
    always_comb begin
        mapped_bits = '0;
        for (int a = 0; a < rename_pkg::NUM_ARCH_REGS; a++) begin
            mapped_bits[map[a]] = 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: logic/spec_rat.sv
`default_nettype none

module spec_rat (
    input  logic                                 clk,
    input  logic                                 arst_n,
    // Slot 0 rs1, slot 0 rs2, slot 1 rs1, slot 1 rs2
    input  rename_pkg::arch_reg_t                src_arch [rename_pkg::NUM_SRCS],
    input  logic [rename_pkg::RENAME_WIDTH-1:0]  wr_en,
    input  rename_pkg::arch_reg_t                wr_arch [rename_pkg::RENAME_WIDTH],
    input  rename_pkg::phys_reg_t                wr_phys [rename_pkg::RENAME_WIDTH],
    input  logic                                 recover,
    input  rename_pkg::phys_reg_t                retire_map [rename_pkg::NUM_ARCH_REGS],
    output rename_pkg::phys_reg_t                src_phys [rename_pkg::NUM_SRCS]
);

    rename_pkg::phys_reg_t map [rename_pkg::NUM_ARCH_REGS];

    //******************************
    // Source reads
    //******************************

    // A source sees the writes of older slots in the same bundle,
    // the youngest older writer wins
    always_comb begin
        for (int s = 0; s < rename_pkg::NUM_SRCS; s++) begin
            src_phys[s] = map[src_arch[s]];
            for (int w = 0; w < rename_pkg::RENAME_WIDTH; w++) begin
                if ((w < s / rename_pkg::SRCS_PER_UOP) && wr_en[w] &&
                    (wr_arch[w] == src_arch[s])) begin
                    src_phys[s] = wr_phys[w];
                end
            end
        end
    end

    //******************************
    // Table update
    //******************************

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            // Identity mapping
            for (int a = 0; a < rename_pkg::NUM_ARCH_REGS; a++) begin
                map[a] <= rename_pkg::phys_reg_t'(a);
            end
        end else if (recover) begin
            // Flash copy from the committed state
            for (int a = 0; a < rename_pkg::NUM_ARCH_REGS; a++) begin
                map[a] <= retire_map[a];
            end
        end else begin
            // Later slot written last so it wins on equal rd
            for (int w = 0; w < rename_pkg::RENAME_WIDTH; w++) begin
                if (wr_en[w]) begin
                    map[wr_arch[w]] <= wr_phys[w];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the rename unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_rename_unit -f compile.f -o sim_rename

./obj_dir/sim_rename +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
    exit 1
fi
exit 0
